// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := cpu_2432_tb
FILELIST  := files.f
LOG       := sim.log
SIM       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(SIM) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== files.f ====
+incdir+src
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/cpu_decode.sv
src/cpu_regfile.sv
src/cpu_alu.sv
src/cpu_branch.sv
src/cpu_control.sv
src/cpu_2432.sv
tb/cpu_2432_checker.sv
tb/cpu_2432_monitor.sv
tb/cpu_2432_tb.sv

// ==== src/cpu_2432.sv ====
`default_nettype none

module cpu_2432
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_clk_en,
  input  logic   i_rstb,
  input  instr_t i_instr,
  input  word_t  i_din,
  output addr_t  o_iaddr,
  output addr_t  o_daddr,
  output word_t  o_dout,
  output logic   o_ram_rd,
  output logic   o_ram_wr
);

  instr_t   dec_instr;
  dec_op_t  dec_op;
  reg_idx_t raddr0, raddr1;
  word_t    rdata0, rdata1;
  exe_op_t  exe_op;
  flags_t   flags, alu_flags;
  word_t    alu_result;
  logic     taken;
  addr_t    target;
  logic     wr_en;
  reg_idx_t waddr;
  word_t    wdata;

  cpu_control u_control (
    .i_clk        (i_clk),
    .i_rstb       (i_rstb),
    .i_clk_en     (i_clk_en),
    .i_instr      (i_instr),
    .i_din        (i_din),
    .i_dec        (dec_op),
    .i_rdata0     (rdata0),
    .i_rdata1     (rdata1),
    .i_alu_result (alu_result),
    .i_alu_flags  (alu_flags),
    .i_taken      (taken),
    .i_target     (target),
    .o_iaddr      (o_iaddr),
    .o_dec_instr  (dec_instr),
    .o_raddr0     (raddr0),
    .o_raddr1     (raddr1),
    .o_exe        (exe_op),
    .o_flags      (flags),
    .o_wr_en      (wr_en),
    .o_waddr      (waddr),
    .o_wdata      (wdata),
    .o_daddr      (o_daddr),
    .o_dout       (o_dout),
    .o_ram_rd     (o_ram_rd),
    .o_ram_wr     (o_ram_wr)
  );

  cpu_decode u_decode (
    .i_instr (dec_instr),
    .o_op    (dec_op)
  );

  cpu_regfile u_regfile (
    .i_clk    (i_clk),
    .i_rstb   (i_rstb),
    .i_clk_en (i_clk_en),
    .i_wr_en  (wr_en),
    .i_waddr  (waddr),
    .i_wdata  (wdata),
    .i_raddr0 (raddr0),
    .i_raddr1 (raddr1),
    .o_rdata0 (rdata0),
    .o_rdata1 (rdata1)
  );

  cpu_alu u_alu (
    .i_op     (exe_op),
    .i_flags  (flags),
    .o_result (alu_result),
    .o_flags  (alu_flags)
  );

  cpu_branch u_branch (
    .i_op     (exe_op),
    .i_flags  (flags),
    .o_taken  (taken),
    .o_target (target)
  );

endmodule

`default_nettype wire

// ==== src/cpu_2432_macros.svh ====
`ifndef CPU_2432_MACROS_SVH
`define CPU_2432_MACROS_SVH

// Datapath and instruction widths
`define CPU_XLEN 32
`define CPU_ILEN 24
`define CPU_ALEN 24

// Register file size
`define CPU_NREGS 16

// JSR writes its return address here
`define CPU_LINK_REG 14

`endif

// ==== src/cpu_alu.sv ====
`default_nettype none

`include "cpu_2432_macros.svh"

module cpu_alu
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  exe_op_t i_op,
  input  flags_t  i_flags,
  output word_t   o_result,
  output flags_t  o_flags
);

  logic [`CPU_XLEN:0] sum;
  logic [`CPU_XLEN:0] diff;
  logic               add_ovf;
  logic               sub_ovf;

  assign sum  = {1'b0, i_op.a} + {1'b0, i_op.b};
  assign diff = {1'b0, i_op.a} + {1'b0, ~i_op.b} + 1'b1;  // Top bit is "no borrow"

  assign add_ovf = (i_op.a[`CPU_XLEN-1] == i_op.b[`CPU_XLEN-1]) &&
                   (sum[`CPU_XLEN-1] != i_op.a[`CPU_XLEN-1]);
  assign sub_ovf = (i_op.a[`CPU_XLEN-1] != i_op.b[`CPU_XLEN-1]) &&
                   (diff[`CPU_XLEN-1] != i_op.a[`CPU_XLEN-1]);

  always_comb begin
    logic set_sz;
    set_sz   = 1'b1;
    o_flags  = i_flags;
    o_result = sum[`CPU_XLEN-1:0];             // Effective address for LD/STO
    case (i_op.op.opcode)
      OP_MOV: o_result = i_op.b;
      OP_ADD: begin
        o_flags.c = sum[`CPU_XLEN];
        o_flags.v = add_ovf;
      end
      OP_SUB, OP_CMP: begin
        o_result  = diff[`CPU_XLEN-1:0];
        o_flags.c = diff[`CPU_XLEN];
        o_flags.v = sub_ovf;
      end
      OP_AND: o_result = i_op.a & i_op.b;
      OP_OR:  o_result = i_op.a | i_op.b;
      OP_XOR: o_result = i_op.a ^ i_op.b;
      default: set_sz = 1'b0;                  // LD flags come from the load data
    endcase
    if (set_sz) begin
      o_flags.s = o_result[`CPU_XLEN-1];
      o_flags.z = (o_result == '0);
    end
  end

endmodule

`default_nettype wire

// ==== src/cpu_branch.sv ====
`default_nettype none

module cpu_branch
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  exe_op_t i_op,
  input  flags_t  i_flags,
  output logic    o_taken,
  output addr_t   o_target
);

  logic  cond_ok;
  addr_t b_addr;

  always_comb begin
    case (i_op.op.cond)
      EQ:      cond_ok = i_flags.z;
      NE:      cond_ok = !i_flags.z;
      CS:      cond_ok = i_flags.c;
      CC:      cond_ok = !i_flags.c;
      MI:      cond_ok = i_flags.s;
      PL:      cond_ok = !i_flags.s;
      VS:      cond_ok = i_flags.v;
      VC:      cond_ok = !i_flags.v;
      HI:      cond_ok = i_flags.c && !i_flags.z;
      LS:      cond_ok = !i_flags.c || i_flags.z;
      GE:      cond_ok = (i_flags.s == i_flags.v);
      LT:      cond_ok = (i_flags.s != i_flags.v);
      GT:      cond_ok = !i_flags.z && (i_flags.s == i_flags.v);
      LE:      cond_ok = i_flags.z || (i_flags.s != i_flags.v);
      default: cond_ok = 1'b1;                 // AL
    endcase
  end

  assign o_taken = (i_op.op.opcode == OP_JMP) || (i_op.op.opcode == OP_JSR) ||
                   ((i_op.op.opcode == OP_JRCC) && cond_ok);

  // b holds the absolute target, the offset or the register value
  assign b_addr   = addr_t'(i_op.b);
  assign o_target = ((i_op.op.opcode == OP_JRCC) && i_op.op.use_imm) ? i_op.pc + b_addr
                                                                      : b_addr;

endmodule

`default_nettype wire

// ==== src/cpu_control.sv ====
`default_nettype none

module cpu_control
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rstb,
  input  logic     i_clk_en,
  input  instr_t   i_instr,
  input  word_t    i_din,
  input  dec_op_t  i_dec,
  input  word_t    i_rdata0,
  input  word_t    i_rdata1,
  input  word_t    i_alu_result,
  input  flags_t   i_alu_flags,
  input  logic     i_taken,
  input  addr_t    i_target,
  output addr_t    o_iaddr,
  output instr_t   o_dec_instr,
  output reg_idx_t o_raddr0,
  output reg_idx_t o_raddr1,
  output exe_op_t  o_exe,
  output flags_t   o_flags,
  output logic     o_wr_en,
  output reg_idx_t o_waddr,
  output word_t    o_wdata,
  output addr_t    o_daddr,
  output word_t    o_dout,
  output logic     o_ram_rd,
  output logic     o_ram_wr
);

  addr_t   pc_q, pc_d;
  instr_t  dec_instr_q;
  addr_t   dec_pc_q;
  logic    dec_valid_q;
  logic    exe_valid_q;
  exe_op_t exe_q, exe_d;
  flags_t  flags_q, flags_d;
  logic    rstb_q;                             // Holds the pipe empty one cycle after reset
  logic    ld_pend_q;                          // i_din belongs to the LD in execute
  logic    taken, stall, dec_move;
  word_t   ea;
  addr_t   link;

  assign taken = exe_valid_q && i_taken;

  // Back-to-back dependency on the execute result, one bubble instead of a bypass
  assign stall = dec_valid_q && exe_valid_q && exe_q.op.rf_wr && (exe_q.op.rd != '0) &&
                 ((i_dec.rs0_use && (i_dec.rs0 == exe_q.op.rd)) ||
                  (i_dec.rs1_use && (i_dec.rs1 == exe_q.op.rd)));
  assign dec_move = dec_valid_q && !stall && !taken;

  always_comb begin
    exe_d.op    = i_dec;
    exe_d.a     = i_rdata0;
    exe_d.b     = i_dec.use_imm ? i_dec.imm : i_rdata1;
    exe_d.sdata = i_rdata1;
    exe_d.pc    = dec_pc_q;
  end

  always_comb begin
    if (taken)                pc_d = i_target; // Jump wins over a stall
    else if (rstb_q && !stall) pc_d = pc_q + 1'b1;
    else                      pc_d = pc_q;
  end

  always_comb begin
    flags_d = i_alu_flags;
    if (ld_pend_q) begin
      flags_d.s = i_din[$bits(word_t)-1];
      flags_d.z = (i_din == '0);
    end
  end

  // Memory access for the instruction about to enter execute
  assign ea       = exe_d.a + exe_d.b;
  assign o_daddr  = addr_t'(ea);
  assign o_dout   = exe_d.sdata;
  assign o_ram_rd = dec_move && (i_dec.opcode == OP_LD);
  assign o_ram_wr = dec_move && (i_dec.opcode == OP_STO);

  // Writeback at the edge that ends execute
  assign link    = exe_q.pc + 1'b1;
  assign o_wr_en = exe_valid_q && exe_q.op.rf_wr;
  assign o_waddr = exe_q.op.rd;
  assign o_wdata = ld_pend_q ? i_din :
                   (exe_q.op.opcode == OP_JSR) ? word_t'(link) : i_alu_result;

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      rstb_q      <= 1'b0;
      pc_q        <= '0;
      dec_valid_q <= 1'b0;
      exe_valid_q <= 1'b0;
      ld_pend_q   <= 1'b0;
      flags_q     <= '0;
    end else if (i_clk_en) begin
      rstb_q <= 1'b1;
      pc_q   <= pc_d;
      if (taken)       dec_valid_q <= 1'b0;    // Squash the fetched instruction
      else if (!stall) dec_valid_q <= rstb_q;
      exe_valid_q <= dec_move;                 // Bubble on stall or squash
      ld_pend_q   <= o_ram_rd;
      if (exe_valid_q) flags_q <= flags_d;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_clk_en) begin
      if (!stall) begin
        dec_instr_q <= i_instr;
        dec_pc_q    <= pc_q;
      end
      exe_q <= exe_d;
    end
  end

  assign o_iaddr     = pc_q;                   // Instruction is sampled at the next enabled edge
  assign o_dec_instr = dec_instr_q;
  assign o_raddr0    = i_dec.rs0;
  assign o_raddr1    = i_dec.rs1;
  assign o_exe       = exe_q;
  assign o_flags     = flags_q;

endmodule

`default_nettype wire

// ==== src/cpu_decode.sv ====
`default_nettype none

`include "cpu_2432_macros.svh"

module cpu_decode
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  instr_t  i_instr,
  output dec_op_t o_op
);

  opcode_e opc;
  imm_t    raw_imm;

  assign opc     = opcode_e'(i_instr[23:19]);
  assign raw_imm = i_instr[9:0];

  always_comb begin
    o_op.opcode  = opc;
    o_op.use_imm = i_instr[18];
    o_op.rd      = i_instr[17:14];
    o_op.cond    = cond_e'(i_instr[17:14]);
    o_op.rs0     = i_instr[13:10];
    o_op.rs1     = i_instr[3:0];
    o_op.imm     = {{(`CPU_XLEN-$bits(imm_t)){raw_imm[$bits(imm_t)-1]}}, raw_imm};
    o_op.rf_wr   = 1'b1;
    o_op.rs0_use = 1'b1;
    o_op.rs1_use = !i_instr[18];
    case (opc)
      OP_MOV: o_op.rs0_use = 1'b0;             // Only operand b is needed
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LD: ;
      OP_CMP: o_op.rf_wr = 1'b0;
      OP_STO: begin
        // Port 1 fetches the store data, so the offset is always immediate
        o_op.rf_wr   = 1'b0;
        o_op.use_imm = 1'b1;
        o_op.rs1     = i_instr[17:14];
        o_op.rs1_use = 1'b1;
      end
      OP_JMP, OP_JSR: begin
        o_op.rf_wr   = (opc == OP_JSR);
        o_op.rd      = reg_idx_t'(`CPU_LINK_REG);
        o_op.use_imm = 1'b1;
        o_op.imm     = {{(`CPU_XLEN-18){1'b0}}, i_instr[17:0]}; // Absolute target
        o_op.rs0_use = 1'b0;
        o_op.rs1_use = 1'b0;
      end
      OP_JRCC: begin
        o_op.rf_wr   = 1'b0;
        o_op.rs0_use = 1'b0;                   // Register form reads only rs1
      end
      default: begin                           // Unknown opcode acts as a no-op
        o_op.rf_wr   = 1'b0;
        o_op.rs0_use = 1'b0;
        o_op.rs1_use = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/cpu_isa_pkg.sv ====
`default_nettype none

`include "cpu_2432_macros.svh"

package cpu_isa_pkg;

  typedef logic [`CPU_XLEN-1:0]          word_t;
  typedef logic [`CPU_ALEN-1:0]          addr_t;
  typedef logic [`CPU_ILEN-1:0]          instr_t;
  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;
  typedef logic [9:0]                    imm_t;    // Raw immediate field, bits 9..0

  // Instruction bits 23..19
  typedef enum logic [4:0] {
    OP_MOV  = 5'h00,
    OP_ADD  = 5'h01,
    OP_SUB  = 5'h02,
    OP_AND  = 5'h03,
    OP_OR   = 5'h04,
    OP_XOR  = 5'h05,
    OP_CMP  = 5'h06,
    OP_LD   = 5'h07,
    OP_STO  = 5'h08,
    OP_JMP  = 5'h09,
    OP_JSR  = 5'h0a,
    OP_JRCC = 5'h0b
  } opcode_e;

  // JRCC condition, held in the rd field
  typedef enum logic [3:0] {
    EQ = 4'd0,  NE = 4'd1,  CS = 4'd2,  CC = 4'd3,
    MI = 4'd4,  PL = 4'd5,  VS = 4'd6,  VC = 4'd7,
    HI = 4'd8,  LS = 4'd9,  GE = 4'd10, LT = 4'd11,
    GT = 4'd12, LE = 4'd13, AL = 4'd15
  } cond_e;

endpackage

`default_nettype wire

// ==== src/cpu_pipe_pkg.sv ====
`default_nettype none

package cpu_pipe_pkg;

  import cpu_isa_pkg::*;

  typedef struct packed {
    logic c;
    logic v;
    logic s;
    logic z;
  } flags_t;

  // Output of the decoder
  typedef struct packed {
    opcode_e  opcode;
    cond_e    cond;
    reg_idx_t rd;
    reg_idx_t rs0;
    reg_idx_t rs1;
    logic     use_imm;
    word_t    imm;       // Already extended to a full word
    logic     rf_wr;
    logic     rs0_use;   // Read-use bits drive the interlock
    logic     rs1_use;
  } dec_op_t;

  // Contents of the execute stage
  typedef struct packed {
    dec_op_t op;
    word_t   a;
    word_t   b;
    word_t   sdata;
    addr_t   pc;
  } exe_op_t;

endpackage

`default_nettype wire

// ==== src/cpu_regfile.sv ====
`default_nettype none

`include "cpu_2432_macros.svh"

module cpu_regfile
  import cpu_isa_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rstb,
  input  logic     i_clk_en,
  input  logic     i_wr_en,
  input  reg_idx_t i_waddr,
  input  word_t    i_wdata,
  input  reg_idx_t i_raddr0,
  input  reg_idx_t i_raddr1,
  output word_t    o_rdata0,
  output word_t    o_rdata1
);

  word_t regs [`CPU_NREGS];

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_clk_en && i_wr_en && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;                // R0 is never written
    end
  end

  // Asynchronous reads
  assign o_rdata0 = (i_raddr0 == '0) ? '0 : regs[i_raddr0];
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];

endmodule

`default_nettype wire

// ==== tb/cpu_2432_checker.sv ====
`default_nettype none

module cpu_2432_checker
  import cpu_isa_pkg::*;
(
  input logic  i_clk,
  input logic  i_clk_en,
  input logic  i_rstb,
  input logic  i_ram_rd,
  input logic  i_ram_wr,
  input addr_t i_iaddr
);

  int         fail_cnt = 0;
  logic [1:0] en_cnt;                          // Enabled edges since reset, saturating

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      en_cnt <= '0;
    end else if (i_clk_en && (en_cnt != 2'd2)) begin
      en_cnt <= en_cnt + 2'd1;
    end
  end

  a_strobe_excl: assert property (@(posedge i_clk) disable iff (!i_rstb)
    !(i_ram_rd && i_ram_wr))
    else begin
      $error("RAM read and write strobes high together");
      fail_cnt++;
    end

  // Covers reset low and the first enabled cycles after it
  a_strobe_reset: assert property (@(posedge i_clk)
    (en_cnt < 2'd2) |-> (!i_ram_rd && !i_ram_wr))
    else begin
      $error("RAM strobe active during or right after reset");
      fail_cnt++;
    end

  a_pc_hold: assert property (@(posedge i_clk) disable iff (!i_rstb)
    !i_clk_en |=> $stable(i_iaddr))
    else begin
      $error("Fetch address moved while clock enable low");
      fail_cnt++;
    end

endmodule

bind cpu_2432 cpu_2432_checker checker_inst (
  .i_clk    (i_clk),
  .i_clk_en (i_clk_en),
  .i_rstb   (i_rstb),
  .i_ram_rd (o_ram_rd),
  .i_ram_wr (o_ram_wr),
  .i_iaddr  (o_iaddr)
);

`default_nettype wire

// ==== tb/cpu_2432_monitor.sv ====
`default_nettype none

module cpu_2432_monitor
  import cpu_isa_pkg::*;
#(
  parameter int MAXQ = 64
) (
  input  logic  i_clk,
  input  logic  i_clk_en,
  input  logic  i_rstb,
  input  logic  i_ram_rd,
  input  logic  i_ram_wr,
  input  addr_t i_daddr,
  input  word_t i_dout,
  input  addr_t i_exp_st_addr [MAXQ],
  input  word_t i_exp_st_data [MAXQ],
  input  int    i_n_st,
  input  addr_t i_exp_ld [MAXQ],
  input  int    i_n_ld,
  input  logic  i_done,
  output int    o_errors,
  output int    o_stores,
  output int    o_loads
);

  logic done_seen = 1'b0;

  always @(posedge i_clk) begin
    if (i_rstb && i_clk_en && i_ram_wr) begin
      if (o_stores >= i_n_st) begin
        $display("Unexpected store to address %h at time %0t beyond the expected list",
                 i_daddr, $time);
        o_errors++;
      end else if ((i_daddr !== i_exp_st_addr[o_stores]) ||
                   (i_dout !== i_exp_st_data[o_stores])) begin
        $display("[ERROR] %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                 o_stores, i_dout, i_daddr, i_exp_st_data[o_stores], i_exp_st_addr[o_stores]);
        o_errors++;
      end
      o_stores++;
    end
    if (i_rstb && i_clk_en && i_ram_rd) begin
      if (o_loads >= i_n_ld) begin
        $display("Unexpected load from address %h at time %0t", i_daddr, $time);
        o_errors++;
      end else if (i_daddr !== i_exp_ld[o_loads]) begin
        $display("[ERROR] %0t: load %0d read %h, expected %h", $time, o_loads,
                 i_daddr, i_exp_ld[o_loads]);
        o_errors++;
      end
      o_loads++;
    end
    // Leftover entries once the program sits in its final loop
    if (i_done && !done_seen) begin
      done_seen = 1'b1;
      if (o_stores < i_n_st) begin
        $display("Program ended with %0d expected stores never seen", i_n_st - o_stores);
        o_errors++;
      end
      if (o_loads < i_n_ld) begin
        $display("Program ended with %0d expected loads never seen", i_n_ld - o_loads);
        o_errors++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/cpu_2432_tb.sv ====
`default_nettype none

module cpu_2432_tb;
  import cpu_isa_pkg::*;

  localparam int MAXQ = 64;

  logic   i_clk = 1'b0;
  logic   i_clk_en;
  logic   i_rstb;
  instr_t i_instr;
  word_t  i_din;
  addr_t  o_iaddr, o_daddr;
  word_t  o_dout;
  logic   o_ram_rd, o_ram_wr;

  instr_t rom [256];
  word_t  ram [256];
  word_t  ram_model [256];                     // RAM image seen by the reference model
  addr_t  st_addr_q[$];
  word_t  st_data_q[$];
  addr_t  ld_q[$];
  addr_t  exp_st_addr [MAXQ];
  word_t  exp_st_data [MAXQ];
  addr_t  exp_ld [MAXQ];
  int     n_st, n_ld, n_instr, pa, halt_hits, total_errors;
  int     mon_errors, mon_stores, mon_loads;
  addr_t  halt_addr, rd_addr;
  logic   done;

  always #20 i_clk = ~i_clk;

  assign i_instr = rom[o_iaddr[7:0]];          // ROM follows the registered fetch address

  cpu_2432 cpu_2432_inst (
    .i_clk    (i_clk),
    .i_clk_en (i_clk_en),
    .i_rstb   (i_rstb),
    .i_instr  (i_instr),
    .i_din    (i_din),
    .o_iaddr  (o_iaddr),
    .o_daddr  (o_daddr),
    .o_dout   (o_dout),
    .o_ram_rd (o_ram_rd),
    .o_ram_wr (o_ram_wr)
  );

  cpu_2432_monitor #(.MAXQ(MAXQ)) monitor_inst (
    .i_clk         (i_clk),
    .i_clk_en      (i_clk_en),
    .i_rstb        (i_rstb),
    .i_ram_rd      (o_ram_rd),
    .i_ram_wr      (o_ram_wr),
    .i_daddr       (o_daddr),
    .i_dout        (o_dout),
    .i_exp_st_addr (exp_st_addr),
    .i_exp_st_data (exp_st_data),
    .i_n_st        (n_st),
    .i_exp_ld      (exp_ld),
    .i_n_ld        (n_ld),
    .i_done        (done),
    .o_errors      (mon_errors),
    .o_stores      (mon_stores),
    .o_loads       (mon_loads)
  );

  function automatic instr_t enc(opcode_e op, bit ui, logic [3:0] rd, logic [3:0] rs0, int imm);
    logic [9:0] f;
    f = imm[9:0];
    return {op, ui, rd, rs0, f};
  endfunction

  function automatic instr_t enc_abs(opcode_e op, int target);
    logic [17:0] t;
    t = target[17:0];
    return {op, 1'b1, t};
  endfunction

  task automatic emit(instr_t ins);
    rom[pa[7:0]] = ins;
    pa++;
  endtask

  function automatic bit cond_true(logic [3:0] cc, logic c, logic v, logic s, logic z);
    case (cc)
      4'd0:    return z;
      4'd1:    return !z;
      4'd2:    return c;
      4'd3:    return !c;
      4'd4:    return s;
      4'd5:    return !s;
      4'd6:    return v;
      4'd7:    return !v;
      4'd8:    return c && !z;
      4'd9:    return !c || z;
      4'd10:   return s == v;
      4'd11:   return s != v;
      4'd12:   return !z && (s == v);
      4'd13:   return z || (s != v);
      default: return 1'b1;
    endcase
  endfunction

  // Instruction-level model, fills the expected store and load lists
  function automatic int iss_run();
    word_t      r [16];
    logic       c, v, s, z, wr, sz;
    addr_t      pc, pc_n, ea;
    instr_t     ins;
    opcode_e    op;
    word_t      a, b, res, imm;
    logic [32:0] t;
    int         n;
    for (int i = 0; i < 16; i++) r[i] = '0;
    {c, v, s, z} = '0;
    pc = '0;
    n = 0;
    while (n < 10000) begin
      ins = rom[pc[7:0]];
      op = opcode_e'(ins[23:19]);
      imm = {{22{ins[9]}}, ins[9:0]};
      a = r[ins[13:10]];
      b = (ins[18] || op == OP_STO) ? imm : r[ins[3:0]];
      n++;
      if (op == OP_JMP && addr_t'(ins[17:0]) == pc) break;
      pc_n = pc + 1;
      ea = addr_t'(a + b);
      wr = 1'b0;
      sz = 1'b1;
      res = '0;
      case (op)
        OP_MOV: begin
          res = b;
          wr = 1'b1;
        end
        OP_ADD: begin
          t = {1'b0, a} + {1'b0, b};
          res = t[31:0];
          c = t[32];
          v = (a[31] == b[31]) && (res[31] != a[31]);
          wr = 1'b1;
        end
        OP_SUB, OP_CMP: begin
          res = a - b;
          c = (a >= b);                        // No borrow
          v = (a[31] != b[31]) && (res[31] != a[31]);
          wr = (op == OP_SUB);
        end
        OP_AND: begin
          res = a & b;
          wr = 1'b1;
        end
        OP_OR: begin
          res = a | b;
          wr = 1'b1;
        end
        OP_XOR: begin
          res = a ^ b;
          wr = 1'b1;
        end
        OP_LD: begin
          ld_q.push_back(ea);
          res = ram_model[ea[7:0]];
          wr = 1'b1;
        end
        OP_STO: begin
          st_addr_q.push_back(ea);
          st_data_q.push_back(r[ins[17:14]]);
          ram_model[ea[7:0]] = r[ins[17:14]];
          sz = 1'b0;
        end
        OP_JMP: begin
          pc_n = addr_t'(ins[17:0]);
          sz = 1'b0;
        end
        OP_JSR: begin
          r[14] = word_t'(addr_t'(pc + 1));
          pc_n = addr_t'(ins[17:0]);
          sz = 1'b0;
        end
        OP_JRCC: begin
          if (cond_true(ins[17:14], c, v, s, z))
            pc_n = ins[18] ? addr_t'(pc + imm[23:0]) : addr_t'(r[ins[3:0]]);
          sz = 1'b0;
        end
        default: sz = 1'b0;
      endcase
      if (wr && ins[17:14] != 4'd0) r[ins[17:14]] = res;
      if (sz) begin
        s = res[31];
        z = (res == '0);
      end
      pc = pc_n;
    end
    return n;
  endfunction

  // Clock enable changes just after each rising edge
  always @(posedge i_clk) begin
    #2;
    i_clk_en <= (($urandom % 4) != 0);
  end

  // Data RAM with one enabled cycle of read latency
  always @(posedge i_clk) begin
    if (i_clk_en && o_ram_wr) ram[o_daddr[7:0]] = o_dout;
    if (i_clk_en && o_ram_rd) begin
      rd_addr = o_daddr;
      #2;
      i_din = ram[rd_addr[7:0]];
    end
  end

  always @(posedge i_clk) begin
    if (i_rstb && i_clk_en && o_iaddr == halt_addr) halt_hits++;
  end

  initial begin
    int b;
    i_clk_en = 1'b0;
    i_rstb = 1'b0;
    i_din = '0;
    done = 1'b0;
    halt_hits = 0;
    n_instr = 0;
    halt_addr = '1;
    pa = 0;
    void'($urandom(32'he011_3eaa));
    for (int i = 0; i < 256; i++) begin
      rom[i] = '0;
      ram[i] = $urandom;
      ram_model[i] = ram[i];
    end
    // A store as the very first instruction lands right behind the delayed reset
    emit(enc(OP_STO, 1, 0, 0, 15));
    // ALU operations, register and immediate forms
    emit(enc(OP_MOV, 1, 1, 0, 100));
    emit(enc(OP_MOV, 1, 2, 0, -7));
    emit(enc(OP_ADD, 0, 3, 1, 2));
    emit(enc(OP_SUB, 1, 4, 2, 5));
    emit(enc(OP_AND, 1, 5, 1, 'h3c));
    emit(enc(OP_OR, 0, 6, 2, 1));
    emit(enc(OP_XOR, 1, 7, 3, 'h155));
    for (int k = 3; k <= 7; k++) emit(enc(OP_STO, 1, k, 0, 13 + k));
    // Back-to-back dependencies
    emit(enc(OP_ADD, 0, 9, 1, 1));
    emit(enc(OP_ADD, 0, 9, 9, 9));
    emit(enc(OP_SUB, 0, 9, 9, 2));
    emit(enc(OP_STO, 1, 9, 0, 21));
    emit(enc(OP_MOV, 1, 10, 0, -300));
    emit(enc(OP_STO, 1, 10, 0, 22));
    // Loads followed by arithmetic
    emit(enc(OP_LD, 1, 10, 0, 40));
    emit(enc(OP_LD, 1, 11, 1, -59));
    emit(enc(OP_ADD, 0, 12, 10, 11));
    emit(enc(OP_STO, 1, 12, 0, 23));
    emit(enc(OP_LD, 0, 13, 1, 2));
    emit(enc(OP_XOR, 0, 13, 13, 12));
    emit(enc(OP_STO, 1, 13, 0, 24));
    // r8 reaches 0x80000000 so one compare overflows
    emit(enc(OP_MOV, 1, 8, 0, 1));
    repeat (31) emit(enc(OP_ADD, 0, 8, 8, 8));
    for (int k = 0; k < 16; k++) begin
      case (k % 4)
        0: emit(enc(OP_CMP, 0, 0, 1, 2));
        1: emit(enc(OP_CMP, 0, 0, 2, 1));
        2: emit(enc(OP_CMP, 0, 0, 1, 1));
        default: emit(enc(OP_CMP, 0, 0, 8, 1));
      endcase
      b = pa;
      emit(enc(OP_JRCC, 1, k, 0, 3));
      emit(enc(OP_MOV, 1, 15, 0, 2 * k));       // Not-taken path
      emit(enc_abs(OP_JMP, b + 4));
      emit(enc(OP_MOV, 1, 15, 0, 2 * k + 1));   // Taken path
      emit(enc(OP_STO, 1, 15, 0, 64 + k));
    end
    // Subroutine call and return through R14
    emit(enc_abs(OP_JSR, 200));
    emit(enc(OP_MOV, 1, 15, 0, 77));
    emit(enc(OP_STO, 1, 15, 0, 90));
    halt_addr = addr_t'(pa);
    emit(enc_abs(OP_JMP, pa));
    pa = 200;
    emit(enc(OP_MOV, 1, 15, 0, 55));
    emit(enc(OP_STO, 1, 15, 0, 91));
    emit(enc(OP_JRCC, 0, 15, 0, 14));
    n_instr = iss_run();
    n_st = (st_addr_q.size() < MAXQ) ? st_addr_q.size() : MAXQ;
    n_ld = (ld_q.size() < MAXQ) ? ld_q.size() : MAXQ;
    for (int i = 0; i < n_st; i++) begin
      exp_st_addr[i] = st_addr_q[i];
      exp_st_data[i] = st_data_q[i];
    end
    for (int i = 0; i < n_ld; i++) exp_ld[i] = ld_q[i];
    repeat (10) @(posedge i_clk);
    #2 i_rstb = 1'b1;
    wait (halt_hits >= 3);
    done = 1'b1;
    repeat (2) @(posedge i_clk);
    total_errors = mon_errors + cpu_2432_inst.checker_inst.fail_cnt;
    $display("Stores %0d of %0d, loads %0d of %0d, errors %0d", mon_stores, n_st,
             mon_loads, n_ld, total_errors);
    if (total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog sized from the model's instruction count
  initial begin
    wait (n_instr > 0);
    #(40 * (8 * n_instr + 20));
    $display("Run timed out after %0t with %0d stores and %0d loads seen", $time,
             mon_stores, mon_loads);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
